//--- common/umi_config.svh
`ifndef UMI_CONFIG_SVH
`define UMI_CONFIG_SVH

// Number of memory banks behind the decoder
// Must be a power of two
`define UMI_NUM_BANKS 4

// 32-bit words held by each bank
`define UMI_BANK_DEPTH 16

// 32-bit words per request or response packet
`define UMI_PKT_WORDS 8

// Address map derived from the values above
// bits 1:0 byte offset, then word index, then bank number
`define UMI_BYTE_BITS 2

`endif

//--- common/umi_pkg.sv
`include "umi_config.svh"

package umi_pkg;

	// Address field positions
	localparam int UMI_IDX_W = $clog2(`UMI_BANK_DEPTH);
	localparam int UMI_SEL_W = $clog2(`UMI_NUM_BANKS);
	localparam int UMI_IDX_LSB = `UMI_BYTE_BITS;
	localparam int UMI_SEL_LSB = `UMI_BYTE_BITS + UMI_IDX_W;

	typedef logic [31:0] umi_addr_t;
	typedef logic [31:0] umi_data_t;
	typedef logic [UMI_IDX_W-1:0] umi_idx_t;
	typedef logic [UMI_SEL_W-1:0] bank_sel_t;

	// Command opcodes, anything else is trapped
	typedef enum logic [7:0] {
		UMI_REQ_READ = 8'h01,
		UMI_REQ_WRITE = 8'h02,
		UMI_RESP_READ = 8'h03
	} umi_cmd_e;

	// Word 0 sits in the low bits, word 7 in the high bits
	typedef struct packed {
		umi_data_t [`UMI_PKT_WORDS-5:0] rsvd;
		umi_data_t data;
		umi_addr_t src;
		umi_addr_t dst;
		logic [23:0] cmd_pad;
		umi_cmd_e cmd;
	} umi_pkt_t;

	// Decoder to bank
	typedef struct packed {
		logic write;
		umi_idx_t idx;
		umi_data_t data;
		umi_addr_t ret_addr;
	} bank_req_t;

	// Bank to arbiter
	typedef struct packed {
		umi_addr_t ret_addr;
		umi_data_t data;
	} bank_rsp_t;

	// Bank number carried in an address
	function automatic bank_sel_t addr_bank(input umi_addr_t addr);
		return addr[UMI_SEL_LSB +: UMI_SEL_W];
	endfunction

	// Word index within a bank
	function automatic umi_idx_t addr_idx(input umi_addr_t addr);
		return addr[UMI_IDX_LSB +: UMI_IDX_W];
	endfunction

endpackage

//--- verilog/umi_rx_decode.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module umi_rx_decode import umi_pkg::*; (
	input logic clk,
	input logic rst,
	input umi_pkt_t rx_pkt,
	input logic rx_valid,
	output logic rx_ready,
	output bank_req_t [`UMI_NUM_BANKS-1:0] req,
	output logic [`UMI_NUM_BANKS-1:0] req_valid,
	input logic [`UMI_NUM_BANKS-1:0] req_ready,
	output logic trap
);

	bank_sel_t sel;
	logic cmd_known;
	logic slot_free;
	logic accept;
	logic rx_en;
	logic [`UMI_NUM_BANKS-1:0] valid_q;
	bank_req_t [`UMI_NUM_BANKS-1:0] req_q;

	assign sel = addr_bank(rx_pkt.dst);
	assign cmd_known = (rx_pkt.cmd == UMI_REQ_READ) || (rx_pkt.cmd == UMI_REQ_WRITE);

	// Addressed slot is empty or handing its request over this cycle
	assign slot_free = !valid_q[sel] || req_ready[sel];

	// Unknown commands never wait on a slot
	assign rx_ready = rx_en && (!cmd_known || slot_free);
	assign accept = rx_valid && rx_ready;

	// Holds rx_ready low for the first cycle out of reset
	always_ff @(posedge clk) begin
		if (rst) begin
			rx_en <= 1'b0;
		end else begin
			rx_en <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_q <= '0;
			trap <= 1'b0;
		end else begin
			for (int i = 0; i < `UMI_NUM_BANKS; i++) begin
				if (req_ready[i]) begin
					valid_q[i] <= 1'b0;
				end
				if (accept && cmd_known && sel == bank_sel_t'(i)) begin
					valid_q[i] <= 1'b1;
				end
			end
			// Sticky until reset
			if (accept && !cmd_known) begin
				trap <= 1'b1;
			end
		end
	end

	// Request payload per bank slot
	always_ff @(posedge clk) begin
		for (int i = 0; i < `UMI_NUM_BANKS; i++) begin
			if (accept && cmd_known && sel == bank_sel_t'(i)) begin
				req_q[i].write <= (rx_pkt.cmd == UMI_REQ_WRITE);
				req_q[i].idx <= addr_idx(rx_pkt.dst);
				req_q[i].data <= rx_pkt.data;
				req_q[i].ret_addr <= rx_pkt.src;
			end
		end
	end

	assign req = req_q;
	assign req_valid = valid_q;

endmodule

//--- umi_bank/umi_bank.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module umi_bank import umi_pkg::*; (
	input logic clk,
	input logic rst,
	input bank_req_t req,
	input logic req_valid,
	output logic req_ready,
	output bank_rsp_t rsp,
	output logic rsp_valid,
	input logic rsp_ready
);

	typedef enum logic [1:0] {
		BANK_IDLE,
		BANK_READ,
		BANK_RESP
	} bank_state_e;

	bank_state_e state;
	umi_data_t mem [`UMI_BANK_DEPTH];
	umi_idx_t rd_idx;
	bank_rsp_t rsp_q;
	logic accept;

	// Only idle banks take requests, a read blocks until its response leaves
	assign req_ready = (state == BANK_IDLE);
	assign accept = req_valid && req_ready;
	assign rsp_valid = (state == BANK_RESP);
	assign rsp = rsp_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BANK_IDLE;
		end else begin
			case (state)
				BANK_IDLE: begin
					if (accept && !req.write) begin
						state <= BANK_READ;
					end
				end
				BANK_READ: begin
					state <= BANK_RESP;
				end
				BANK_RESP: begin
					if (rsp_ready) begin
						state <= BANK_IDLE;
					end
				end
				default: begin
					state <= BANK_IDLE;
				end
			endcase
		end
	end

	// Posted write lands at the accepting edge
	always_ff @(posedge clk) begin
		if (accept && req.write) begin
			mem[req.idx] <= req.data;
		end
	end

	// Read address and return address captured on accept
	always_ff @(posedge clk) begin
		if (accept && !req.write) begin
			rd_idx <= req.idx;
			rsp_q.ret_addr <= req.ret_addr;
		end
	end

	// Synchronous array read, then held until taken
	always_ff @(posedge clk) begin
		if (state == BANK_READ) begin
			rsp_q.data <= mem[rd_idx];
		end
	end

endmodule

//--- verilog/umi_tx_arbiter.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module umi_tx_arbiter import umi_pkg::*; (
	input logic clk,
	input logic rst,
	input bank_rsp_t [`UMI_NUM_BANKS-1:0] rsp,
	input logic [`UMI_NUM_BANKS-1:0] rsp_valid,
	output logic [`UMI_NUM_BANKS-1:0] rsp_ready,
	output umi_pkt_t tx_pkt,
	output logic tx_valid,
	input logic tx_ready
);

	bank_sel_t rr_ptr;
	bank_sel_t gnt_idx;
	logic gnt_any;
	logic load_ok;
	logic tx_valid_q;
	umi_pkt_t tx_pkt_q;
	umi_pkt_t pkt_d;

	// Output register can take a new packet
	assign load_ok = !tx_valid_q || tx_ready;

	// First valid bank at or after the pointer
	always_comb begin
		bank_sel_t cand;
		gnt_any = 1'b0;
		gnt_idx = rr_ptr;
		for (int k = 0; k < `UMI_NUM_BANKS; k++) begin
			// Pointer wraps since the bank count is a power of two
			cand = rr_ptr + bank_sel_t'(k);
			if (!gnt_any && rsp_valid[cand]) begin
				gnt_any = 1'b1;
				gnt_idx = cand;
			end
		end
	end

	always_comb begin
		rsp_ready = '0;
		rsp_ready[gnt_idx] = gnt_any && load_ok;
	end

	// Read response built from the granted bank
	always_comb begin
		pkt_d = '0;
		pkt_d.cmd = UMI_RESP_READ;
		pkt_d.dst = rsp[gnt_idx].ret_addr;
		pkt_d.data = rsp[gnt_idx].data;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			tx_valid_q <= 1'b0;
			rr_ptr <= '0;
		end else if (load_ok) begin
			tx_valid_q <= gnt_any;
			if (gnt_any) begin
				rr_ptr <= gnt_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load_ok && gnt_any) begin
			tx_pkt_q <= pkt_d;
		end
	end

	assign tx_pkt = tx_pkt_q;
	assign tx_valid = tx_valid_q;

endmodule

//--- verilog/zverif_top.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module zverif_top import umi_pkg::*; (
	input logic clk,
	input logic rst,
	input umi_pkt_t rx_pkt,
	input logic rx_valid,
	output logic rx_ready,
	output umi_pkt_t tx_pkt,
	output logic tx_valid,
	input logic tx_ready,
	output logic trap
);

	// Decoder to banks
	bank_req_t [`UMI_NUM_BANKS-1:0] req;
	logic [`UMI_NUM_BANKS-1:0] req_valid;
	logic [`UMI_NUM_BANKS-1:0] req_ready;

	// Banks to arbiter
	bank_rsp_t [`UMI_NUM_BANKS-1:0] rsp;
	logic [`UMI_NUM_BANKS-1:0] rsp_valid;
	logic [`UMI_NUM_BANKS-1:0] rsp_ready;

	umi_rx_decode u_decode (
		.clk(clk),
		.rst(rst),
		.rx_pkt(rx_pkt),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.req(req),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.trap(trap)
	);

	for (genvar g = 0; g < `UMI_NUM_BANKS; g++) begin : g_bank
		umi_bank u_bank (
			.clk(clk),
			.rst(rst),
			.req(req[g]),
			.req_valid(req_valid[g]),
			.req_ready(req_ready[g]),
			.rsp(rsp[g]),
			.rsp_valid(rsp_valid[g]),
			.rsp_ready(rsp_ready[g])
		);
	end

	umi_tx_arbiter u_arbiter (
		.clk(clk),
		.rst(rst),
		.rsp(rsp),
		.rsp_valid(rsp_valid),
		.rsp_ready(rsp_ready),
		.tx_pkt(tx_pkt),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready)
	);

endmodule

//--- verif/umi_chk.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module umi_chk import umi_pkg::*; (
	input logic clk,
	input logic rst,
	input umi_pkt_t rx_pkt,
	input logic rx_valid,
	input logic rx_ready,
	input umi_pkt_t tx_pkt,
	input logic tx_valid,
	input logic tx_ready,
	input logic trap
);

	int err_count = 0;

	// Nothing offered, accepted or trapped right out of reset
	a_reset_quiet: assert property (@(posedge clk) rst |=> !tx_valid && !rx_ready && !trap)
		else begin
			$error("outputs active after reset");
			err_count++;
		end

	// Stalled response holds its packet
	a_tx_hold: assert property (@(posedge clk) disable iff (rst)
		tx_valid && !tx_ready |=> tx_valid && $stable(tx_pkt))
		else begin
			$error("tx packet changed or dropped while stalled");
			err_count++;
		end

	a_rx_hold: assert property (@(posedge clk) disable iff (rst)
		rx_valid && !rx_ready |=> rx_valid && $stable(rx_pkt))
		else begin
			$error("rx packet changed or dropped while stalled");
			err_count++;
		end

	a_trap_sticky: assert property (@(posedge clk) disable iff (rst) trap |=> trap)
		else begin
			$error("trap fell without reset");
			err_count++;
		end

	// Only read responses leave the target
	a_tx_cmd: assert property (@(posedge clk) disable iff (rst)
		tx_valid |-> tx_pkt.cmd == UMI_RESP_READ)
		else begin
			$error("tx packet is not a read response");
			err_count++;
		end

endmodule

bind zverif_top umi_chk u_chk (
	.clk(clk),
	.rst(rst),
	.rx_pkt(rx_pkt),
	.rx_valid(rx_valid),
	.rx_ready(rx_ready),
	.tx_pkt(tx_pkt),
	.tx_valid(tx_valid),
	.tx_ready(tx_ready),
	.trap(trap)
);

//--- verif/testbench.sv
`timescale 1ns/1ps
`include "umi_config.svh"

module testbench import umi_pkg::*; ();

	localparam int NUM_PKTS = 240;
	localparam int RESET_CYCLES = 5;
	localparam int NB = `UMI_NUM_BANKS;
	localparam int DEPTH = `UMI_BANK_DEPTH;
	localparam int IDX_W = $clog2(DEPTH);
	localparam int SEL_W = $clog2(NB);

	// Expected read response with its return address and data
	typedef struct packed {
		umi_addr_t src;
		umi_data_t data;
	} rd_exp_t;

	logic clk = 1'b0;
	logic rst;
	umi_pkt_t rx_pkt;
	logic rx_valid;
	logic rx_ready;
	umi_pkt_t tx_pkt;
	logic tx_valid;
	logic tx_ready = 1'b0;
	logic trap;

	logic [15:0] stim_lfsr = 16'd7053;
	logic [15:0] rdy_lfsr = 16'd7053;
	umi_data_t ref_mem [NB][DEPTH];
	bit written [NB][DEPTH];
	rd_exp_t exp_q [NB][$];
	logic trap_due = 1'b0;
	int unsigned rd_seq = 0;

	zverif_top DUT (
		.clk(clk),
		.rst(rst),
		.rx_pkt(rx_pkt),
		.rx_valid(rx_valid),
		.rx_ready(rx_ready),
		.tx_pkt(tx_pkt),
		.tx_valid(tx_valid),
		.tx_ready(tx_ready),
		.trap(trap)
	);

	always #5 clk = ~clk;

	// Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		if (s[0]) begin
			return (s >> 1) ^ 16'hB400;
		end
		return s >> 1;
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			stim_lfsr = lfsr_next(stim_lfsr);
			v = {v[30:0], stim_lfsr[0]};
		end
		return v;
	endfunction

	// Ignored address bits get random filler
	function automatic umi_pkt_t build_pkt(input umi_cmd_e cmd, input logic [31:0] bank,
			input logic [31:0] idx, input umi_data_t data, input umi_addr_t src);
		umi_pkt_t p;
		umi_addr_t dst;
		dst = rand_bits(32) << (2 + IDX_W + SEL_W);
		dst = dst | (bank << (2 + IDX_W)) | (idx << 2) | rand_bits(2);
		p = '0;
		p.cmd = cmd;
		p.dst = dst;
		p.src = src;
		p.data = data;
		return p;
	endfunction

	function automatic int pending_reads();
		int n;
		n = 0;
		for (int b = 0; b < NB; b++) begin
			n += exp_q[b].size();
		end
		return n;
	endfunction

	task automatic stop_with_failure();
		$display("STATUS: FAIL");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		$display("mismatch at %0t: %s", $time, msg);
		stop_with_failure();
	endtask

	task automatic send_pkt(input umi_pkt_t pkt);
		int gap;
		gap = int'(rand_bits(2));
		repeat (gap) begin
			@(negedge clk);
		end
		rx_pkt = pkt;
		rx_valid = 1'b1;
		@(posedge clk);
		while (!rx_ready) begin
			@(posedge clk);
		end
		@(negedge clk);
		rx_valid = 1'b0;
	endtask

	// Return address carries the bank number in its low byte
	task automatic check_response(input umi_pkt_t pkt);
		int b;
		rd_exp_t head;
		b = int'(pkt.dst[7:0]);
		assert (b < NB && exp_q[b].size() > 0)
			else report_mismatch($sformatf("response to %h has no pending read", pkt.dst));
		head = exp_q[b].pop_front();
		assert (pkt.cmd == UMI_RESP_READ)
			else report_mismatch($sformatf("response command %h", pkt.cmd));
		assert (pkt.dst == head.src)
			else report_mismatch($sformatf("dst %h, expected %h", pkt.dst, head.src));
		assert (pkt.data == head.data)
			else report_mismatch($sformatf("data %h, expected %h", pkt.data, head.data));
		assert (pkt.src == '0 && pkt.cmd_pad == '0 && pkt.rsvd == '0)
			else report_mismatch("unused response words are not zero");
	endtask

	always @(posedge clk) begin
		if (!rst && tx_valid && tx_ready) begin
			check_response(tx_pkt);
		end
	end

	// Trap rises after the unknown command and stays high
	always @(posedge clk) begin
		if (!rst) begin
			assert (trap == trap_due)
				else report_mismatch($sformatf("trap is %b, expected %b", trap, trap_due));
		end
	end

	always @(negedge clk) begin
		if (DUT.u_chk.err_count != 0) begin
			$display("Protocol checker reported a handshake or reset violation");
			stop_with_failure();
		end
	end

	// Sink is ready about three cycles out of four
	always @(negedge clk) begin
		logic b0;
		rdy_lfsr = lfsr_next(rdy_lfsr);
		b0 = rdy_lfsr[0];
		rdy_lfsr = lfsr_next(rdy_lfsr);
		tx_ready = b0 | rdy_lfsr[0];
	end

	initial begin
		repeat (RESET_CYCLES + 1 + NUM_PKTS * 40) begin
			@(posedge clk);
		end
		$display("Timeout with %0d read responses still missing", pending_reads());
		stop_with_failure();
	end

	initial begin
		logic [31:0] bank;
		logic [31:0] idx;
		logic [31:0] last_bank;
		logic [31:0] last_idx;
		logic do_read;
		umi_data_t data;
		umi_addr_t src;
		rd_exp_t entry;
		rst = 1'b1;
		rx_valid = 1'b0;
		rx_pkt = '0;
		last_bank = '0;
		last_idx = '0;
		repeat (RESET_CYCLES) begin
			@(posedge clk);
		end
		@(negedge clk);
		rst = 1'b0;
		for (int k = 0; k < NUM_PKTS; k++) begin
			bank = rand_bits(SEL_W);
			idx = rand_bits(IDX_W);
			if (k == NUM_PKTS / 2) begin
				// Unknown opcode at a written word followed by a read of that word
				bank = last_bank;
				idx = last_idx;
				send_pkt(build_pkt(umi_cmd_e'(8'h7f), bank, idx, ~ref_mem[bank][idx], '0));
				trap_due = 1'b1;
				do_read = 1'b1;
			end else begin
				do_read = written[bank][idx] && (rand_bits(1) != 0);
			end
			if (do_read) begin
				src = 32'h4000_0000 | (rd_seq << 8) | bank;
				rd_seq++;
				send_pkt(build_pkt(UMI_REQ_READ, bank, idx, rand_bits(32), src));
				entry.src = src;
				entry.data = ref_mem[bank][idx];
				exp_q[bank].push_back(entry);
			end else begin
				data = rand_bits(32);
				send_pkt(build_pkt(UMI_REQ_WRITE, bank, idx, data, '0));
				ref_mem[bank][idx] = data;
				written[bank][idx] = 1'b1;
				last_bank = bank;
				last_idx = idx;
			end
		end
		while (pending_reads() != 0) begin
			@(posedge clk);
		end
		// Room for a duplicate response to show up
		repeat (20) begin
			@(posedge clk);
		end
		@(negedge clk);
		if (DUT.u_chk.err_count == 0) begin
			$display("STATUS: PASS");
			$finish;
		end else begin
			stop_with_failure();
		end
	end

endmodule

//--- flist.f
+incdir+common
common/umi_pkg.sv
verilog/umi_rx_decode.sv
umi_bank/umi_bank.sv
verilog/umi_tx_arbiter.sv
verilog/zverif_top.sv
verif/umi_chk.sv
verif/testbench.sv

//--- run.sh
#!/bin/sh
# Build and run the UMI memory target testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module testbench \
	-f flist.f -Mdir obj_dir -o sim_umi > build.log 2>&1
if [ $? -ne 0 ]; then
	cat build.log
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_umi > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	echo "Simulation passed"
	exit 0
fi
echo "Pass message not found in sim.log"
exit 1
